//--- verilog.f
hw/lcd_pkg.sv
hw/spi_byte_if.sv
hw/spi_byte_tx.sv
hw/init_rom.sv
hw/lcd_controller.sv
hw/lcd_top.sv
sim/clock_gen.sv
sim/lcd_properties.sv
sim/tb_lcd_top.sv

//--- Makefile
# Verilator build and run for the ILI9341 SPI controller

TOP = tb_lcd_top
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Verification passed" $(LOG); then \
		echo "TEST PASS"; \
	else \
		echo "TEST FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- sim/tb_lcd_top.sv
// ILI9341 controller testbench
`timescale 1ns/10ps
module tb_lcd_top;

    localparam int init_total = 84;
    localparam int host_loads = 40;
    localparam int timeout_cycles = 40000;

    logic CLK_100MHz;
    logic reset;
    logic load;
    logic is_cmd;
    logic [7:0] data_in;
    logic busy;
    logic ready;
    logic tft_cs;
    logic tft_reset;
    logic tft_sdi;
    logic tft_sck;
    logic tft_dc;

    // Power-up bytes in send order, and the length of each command span
    logic [7:0] init_bytes [0:83] = '{
        8'h01, 8'h28,
        8'hCB, 8'h39, 8'h2C, 8'h00, 8'h34, 8'h02,
        8'hCF, 8'h00, 8'hC1, 8'h30,
        8'hE8, 8'h85, 8'h00, 8'h78,
        8'hEA, 8'h00, 8'h00,
        8'hED, 8'h64, 8'h03, 8'h12, 8'h81,
        8'hF7, 8'h20, 8'hC0, 8'h23, 8'hC1, 8'h10,
        8'hC5, 8'h3E, 8'h28,
        8'hC7, 8'h86, 8'h36, 8'h48, 8'h3A, 8'h55,
        8'hB1, 8'h00, 8'h18,
        8'hB6, 8'h08, 8'h82, 8'h27,
        8'hF2, 8'h00, 8'h26, 8'h01,
        8'hE0, 8'h0F, 8'h31, 8'h2B, 8'h0C, 8'h0E, 8'h08, 8'h4E,
        8'hF1, 8'h37, 8'h07, 8'h10, 8'h03, 8'h0E, 8'h09, 8'h00,
        8'hE1, 8'h00, 8'h0E, 8'h14, 8'h03, 8'h11, 8'h07, 8'h31,
        8'hC1, 8'h48, 8'h08, 8'h0F, 8'h0C, 8'h31, 8'h36, 8'h0F,
        8'h11, 8'h29
    };
    int span_len [0:21] = '{1, 1, 6, 4, 4, 3, 5, 2, 2, 2, 3, 2, 2, 2, 3, 4, 2, 2, 16, 16, 1, 1};

    // Decoded and expected {dc, byte} pairs
    logic [8:0] decoded_q [$];
    logic [8:0] host_q [$];
    logic [8:0] got;
    logic [8:0] expected;
    logic has_expected;

    int mismatches = 0;
    int other_errors = 0;
    int compared = 0;
    int decoded_total = 0;
    int frames = 0;
    int cycles = 0;
    int nbits = 0;
    logic [7:0] rx_byte;
    logic sck_q;
    logic cs_q;
    logic ready_q;
    logic reset_low_seen = 1'b0;
    logic [7:0] host_data;
    logic host_cmd;
    int i;

    clock_gen clocks (
        .CLK_100MHz (CLK_100MHz),
        .reset      (reset)
    );

    lcd_top #(
        .tick_cycles (10)
    ) uut (
        .CLK_100MHz (CLK_100MHz),
        .reset      (reset),
        .load       (load),
        .is_cmd     (is_cmd),
        .data_in    (data_in),
        .busy       (busy),
        .ready      (ready),
        .tft_cs     (tft_cs),
        .tft_reset  (tft_reset),
        .tft_sdi    (tft_sdi),
        .tft_sck    (tft_sck),
        .tft_dc     (tft_dc)
    );

    // Expected init pair, the first byte of each span is a command
    function automatic logic [8:0] init_pair(input int k);
        int first;
        int s;
        logic dc;
        first = 0;
        dc = 1'b1;
        for (s = 0; s < 22; s++) begin
            if (k == first) begin
                dc = 1'b0;
            end
            first += span_len[s];
        end
        return {dc, init_bytes[k]};
    endfunction

    // Host bytes go out with dc as the inverse of is_cmd
    function automatic logic [8:0] host_pair(input logic [7:0] b, input logic cmd);
        return {!cmd, b};
    endfunction

    // SPI decoder and pin monitor
    always @(posedge CLK_100MHz) begin
        if (reset) begin
            sck_q <= 1'b0;
            cs_q <= 1'b1;
            ready_q <= 1'b0;
            nbits = 0;
        end else begin
            sck_q <= tft_sck;
            cs_q <= tft_cs;
            ready_q <= ready;
            if (!tft_reset) begin
                reset_low_seen <= 1'b1;
            end
            if (!tft_reset && !tft_cs) begin
                other_errors++;
                $display("Panel reset is low during an SPI frame at %0t", $time);
            end
            if (!tft_cs && cs_q) begin
                frames++;
            end
            if (tft_cs && !cs_q && nbits != 8) begin
                other_errors++;
                $display("Frame ended after %0d bits at %0t", nbits, $time);
            end
            if (tft_cs) begin
                nbits = 0;
            end else if (tft_sck && !sck_q) begin
                rx_byte = {rx_byte[6:0], tft_sdi};
                nbits++;
                if (nbits == 8) begin
                    decoded_q.push_back({tft_dc, rx_byte});
                    decoded_total++;
                end
            end
            if (ready && !ready_q) begin
                if (decoded_total != init_total || busy) begin
                    mismatches++;
                    $display("Mismatch at %0t: ready rose with %0d bytes decoded, busy %0b",
                             $time, decoded_total, busy);
                end
            end
        end
    end

    // Compare each decoded byte with the reference
    always @(posedge CLK_100MHz) begin
        if (decoded_q.size() != 0) begin
            got = decoded_q.pop_front();
            has_expected = 1'b1;
            if (compared < init_total) begin
                expected = init_pair(compared);
            end else if (host_q.size() != 0) begin
                expected = host_q.pop_front();
            end else begin
                has_expected = 1'b0;
                other_errors++;
                $display("Extra frame with byte %02h decoded at %0t", got[7:0], $time);
            end
            if (has_expected && got != expected) begin
                mismatches++;
                $display("Mismatch at %0t: byte %0d expected %02h dc %0b, got %02h dc %0b",
                         $time, compared, expected[7:0], expected[8], got[7:0], got[8]);
            end
            compared++;
        end
    end

    // Run limit
    always @(posedge CLK_100MHz) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                     mismatches, other_errors, uut.props.failures);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        load = 1'b0;
        is_cmd = 1'b0;
        data_in = 8'h00;
        void'($urandom(21157));

        @(posedge CLK_100MHz);
        while (reset) @(posedge CLK_100MHz);
        if (ready || !busy || !tft_cs || !tft_reset || tft_sck) begin
            mismatches++;
            $display("Mismatch at %0t: after reset ready %0b busy %0b cs %0b rst %0b sck %0b",
                     $time, ready, busy, tft_cs, tft_reset, tft_sck);
        end

        while (!ready) @(posedge CLK_100MHz);

        for (i = 0; i < host_loads; i++) begin
            while (!(ready && !busy)) @(posedge CLK_100MHz);
            host_data = 8'($urandom);
            host_cmd = 1'($urandom);
            load <= 1'b1;
            data_in <= host_data;
            is_cmd <= host_cmd;
            host_q.push_back(host_pair(host_data, host_cmd));
            @(posedge CLK_100MHz);
            load <= 1'b0;
            @(posedge CLK_100MHz);
            // Every other byte, try a load in the middle of the frame
            if (i % 2 == 1) begin
                repeat (8) @(posedge CLK_100MHz);
                if (!busy) begin
                    other_errors++;
                    $display("Host port not busy during a frame at %0t", $time);
                end
                load <= 1'b1;
                data_in <= ~host_data;
                is_cmd <= !host_cmd;
                @(posedge CLK_100MHz);
                load <= 1'b0;
            end
        end

        while (busy) @(posedge CLK_100MHz);
        repeat (10) @(posedge CLK_100MHz);

        if (frames != init_total + host_loads || compared != init_total + host_loads) begin
            mismatches++;
            $display("Mismatch at %0t: %0d frames, %0d bytes compared, expected %0d",
                     $time, frames, compared, init_total + host_loads);
        end
        if (!reset_low_seen) begin
            other_errors++;
            $display("Panel reset was never driven low");
        end

        $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, other_errors, uut.props.failures);
        if (mismatches == 0 && other_errors == 0 && uut.props.failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sim/lcd_properties.sv
// SPI framing and host port assertions
`timescale 1ns/10ps
module lcd_properties (
    input logic CLK_100MHz,
    input logic reset,
    input logic tft_cs,
    input logic tft_sck,
    input logic busy,
    input logic ready
);

    int failures = 0;

    // SCK idles low outside a frame
    sck_idle_low: assert property (
        @(posedge CLK_100MHz) disable iff (reset) tft_cs |-> !tft_sck
    ) else begin
        failures++;
        $error("tft_sck high while tft_cs is high");
    end

    // Host sees busy for the whole frame
    busy_during_frame: assert property (
        @(posedge CLK_100MHz) disable iff (reset) !tft_cs |-> busy
    ) else begin
        failures++;
        $error("busy low while tft_cs is low");
    end

    // Once ready, the controller stays ready
    ready_sticky: assert property (
        @(posedge CLK_100MHz) disable iff (reset) ready |=> ready
    ) else begin
        failures++;
        $error("ready fell after it had risen");
    end

endmodule

bind lcd_top lcd_properties props (
    .CLK_100MHz (CLK_100MHz),
    .reset      (reset),
    .tft_cs     (tft_cs),
    .tft_sck    (tft_sck),
    .busy       (busy),
    .ready      (ready)
);

//--- sim/clock_gen.sv
// Testbench clock and reset
`timescale 1ns/10ps
module clock_gen (
    output logic CLK_100MHz,
    output logic reset
);

    // 10 ns period
    initial begin
        CLK_100MHz = 1'b0;
        forever #5 CLK_100MHz = ~CLK_100MHz;
    end

    // Reset held for 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge CLK_100MHz);
        reset <= 1'b0;
    end

endmodule

//--- hw/lcd_top.sv
// ILI9341 SPI controller top
`timescale 1ns/10ps
module lcd_top #(
    parameter int tick_cycles = 100000
) (
    input  logic               CLK_100MHz,
    input  logic               reset,
    input  logic               load,
    input  logic               is_cmd,
    input  lcd_pkg::lcd_byte_t data_in,
    output logic               busy,
    output logic               ready,
    output logic               tft_cs,
    output logic               tft_reset,
    output logic               tft_sdi,
    output logic               tft_sck,
    output logic               tft_dc
);

    spi_byte_if link ();

    lcd_controller #(
        .tick_cycles (tick_cycles)
    ) controller (
        .CLK_100MHz (CLK_100MHz),
        .reset      (reset),
        .load       (load),
        .is_cmd     (is_cmd),
        .data_in    (data_in),
        .busy       (busy),
        .ready      (ready),
        .tft_reset  (tft_reset),
        .link       (link.ctrl)
    );

    spi_byte_tx transmitter (
        .CLK_100MHz (CLK_100MHz),
        .reset      (reset),
        .link       (link.tx),
        .tft_cs     (tft_cs),
        .tft_sck    (tft_sck),
        .tft_sdi    (tft_sdi),
        .tft_dc     (tft_dc)
    );

endmodule

//--- hw/lcd_controller.sv
// ILI9341 init sequencer and host port
`timescale 1ns/10ps
module lcd_controller #(
    parameter int tick_cycles = 100000
) (
    input  logic               CLK_100MHz,
    input  logic               reset,
    input  logic               load,
    input  logic               is_cmd,
    input  lcd_pkg::lcd_byte_t data_in,
    output logic               busy,
    output logic               ready,
    output logic               tft_reset,
    spi_byte_if.ctrl           link
);

    lcd_pkg::ctrl_state_t state;
    lcd_pkg::step_idx_t step;
    logic [4:0] byte_idx;
    lcd_pkg::wait_t wait_cnt;
    logic [$clog2(tick_cycles)-1:0] tick_cnt;
    logic tick;

    lcd_pkg::rom_addr_t rom_addr;
    lcd_pkg::rom_addr_t rom_first;
    logic [4:0] rom_count;
    lcd_pkg::wait_t rom_wait;
    logic rom_level;
    logic rom_last;
    lcd_pkg::lcd_byte_t rom_data;

    logic wait_done;
    logic link_free;
    logic issue_init;
    logic issue_host;

    init_rom rom (
        .step        (step),
        .addr        (rom_addr),
        .first       (rom_first),
        .count       (rom_count),
        .wait_len    (rom_wait),
        .reset_level (rom_level),
        .last        (rom_last),
        .data        (rom_data)
    );

    assign rom_addr = rom_first + lcd_pkg::rom_addr_t'(byte_idx);
    assign wait_done = (wait_cnt == rom_wait);

    // Start is still visible the cycle before the transmitter raises busy
    assign link_free = !link.busy && !link.start;
    assign issue_init = (state == lcd_pkg::send_step) && link_free && (byte_idx != rom_count);
    assign issue_host = (state == lcd_pkg::ready_idle) && load;

    // Free running wait tick
    always_ff @(posedge CLK_100MHz) begin
        if (reset) begin
            tick_cnt <= '0;
            tick <= 1'b0;
        end else if (int'(tick_cnt) == tick_cycles - 1) begin
            tick_cnt <= '0;
            tick <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    always_ff @(posedge CLK_100MHz) begin
        if (reset) begin
            state <= lcd_pkg::reset_wait;
            step <= '0;
            byte_idx <= '0;
            wait_cnt <= '0;
            busy <= 1'b1;
            ready <= 1'b0;
            tft_reset <= 1'b1;
            link.start <= 1'b0;
        end else begin
            link.start <= issue_init || issue_host;
            tft_reset <= rom_level;
            case (state)
                lcd_pkg::reset_wait: begin
                    if (wait_done) begin
                        wait_cnt <= '0;
                        step <= step + 1'b1;
                        if (step == lcd_pkg::step_idx_t'(lcd_pkg::PIN_STEPS - 1)) begin
                            byte_idx <= '0;
                            state <= lcd_pkg::send_step;
                        end
                    end else if (tick) begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                lcd_pkg::send_step: begin
                    if (issue_init) begin
                        byte_idx <= byte_idx + 1'b1;
                    end else if (link_free) begin
                        // Last byte of the span has left the transmitter
                        wait_cnt <= '0;
                        state <= lcd_pkg::step_wait;
                    end
                end
                lcd_pkg::step_wait: begin
                    if (wait_done) begin
                        if (rom_last) begin
                            ready <= 1'b1;
                            busy <= 1'b0;
                            state <= lcd_pkg::ready_idle;
                        end else begin
                            step <= step + 1'b1;
                            byte_idx <= '0;
                            state <= lcd_pkg::send_step;
                        end
                    end else if (tick) begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                lcd_pkg::ready_idle: begin
                    if (issue_host) begin
                        busy <= 1'b1;
                        state <= lcd_pkg::host_send;
                    end
                end
                lcd_pkg::host_send: begin
                    if (link_free) begin
                        busy <= 1'b0;
                        state <= lcd_pkg::ready_idle;
                    end
                end
                default: state <= lcd_pkg::reset_wait;
            endcase
        end
    end

    // First byte of a step is the command, the rest are arguments
    always_ff @(posedge CLK_100MHz) begin
        if (issue_init) begin
            link.data <= rom_data;
            link.dc <= (byte_idx != 5'd0);
        end else if (issue_host) begin
            link.data <= data_in;
            link.dc <= !is_cmd;
        end
    end

endmodule

//--- hw/init_rom.sv
// ILI9341 power-up table
`timescale 1ns/10ps
module init_rom (
    input  lcd_pkg::step_idx_t step,
    input  lcd_pkg::rom_addr_t addr,
    output lcd_pkg::rom_addr_t first,
    output logic [4:0]         count,
    output lcd_pkg::wait_t     wait_len,
    output logic               reset_level,
    output logic               last,
    output lcd_pkg::lcd_byte_t data
);

    logic [21:0] row;
    lcd_pkg::lcd_byte_t mem [0:lcd_pkg::ROM_BYTES-1];

    // Row is {first, count, wait, reset level}
    always_comb begin
        case (step)
            5'd0:    row = {7'd0, 5'd0, 9'd5, 1'b1};
            5'd1:    row = {7'd0, 5'd0, 9'd20, 1'b0};
            5'd2:    row = {7'd0, 5'd0, 9'd150, 1'b1};
            5'd3:    row = {7'd0, 5'd1, 9'd150, 1'b1};
            5'd4:    row = {7'd1, 5'd1, 9'd0, 1'b1};
            5'd5:    row = {7'd2, 5'd6, 9'd0, 1'b1};
            5'd6:    row = {7'd8, 5'd4, 9'd0, 1'b1};
            5'd7:    row = {7'd12, 5'd4, 9'd0, 1'b1};
            5'd8:    row = {7'd16, 5'd3, 9'd0, 1'b1};
            5'd9:    row = {7'd19, 5'd5, 9'd0, 1'b1};
            5'd10:   row = {7'd24, 5'd2, 9'd0, 1'b1};
            5'd11:   row = {7'd26, 5'd2, 9'd0, 1'b1};
            5'd12:   row = {7'd28, 5'd2, 9'd0, 1'b1};
            5'd13:   row = {7'd30, 5'd3, 9'd0, 1'b1};
            5'd14:   row = {7'd33, 5'd2, 9'd0, 1'b1};
            5'd15:   row = {7'd35, 5'd2, 9'd0, 1'b1};
            5'd16:   row = {7'd37, 5'd2, 9'd0, 1'b1};
            5'd17:   row = {7'd39, 5'd3, 9'd0, 1'b1};
            5'd18:   row = {7'd42, 5'd4, 9'd0, 1'b1};
            5'd19:   row = {7'd46, 5'd2, 9'd0, 1'b1};
            5'd20:   row = {7'd48, 5'd2, 9'd0, 1'b1};
            5'd21:   row = {7'd50, 5'd16, 9'd0, 1'b1};
            5'd22:   row = {7'd66, 5'd16, 9'd0, 1'b1};
            5'd23:   row = {7'd82, 5'd1, 9'd120, 1'b1};
            5'd24:   row = {7'd83, 5'd1, 9'd100, 1'b1};
            default: row = {7'd0, 5'd0, 9'd0, 1'b1};
        endcase
    end

    assign first = row[21:15];
    assign count = row[14:10];
    assign wait_len = row[9:1];
    assign reset_level = row[0];

    // Display on closes the sequence
    assign last = (step == lcd_pkg::step_idx_t'(lcd_pkg::PIN_STEPS + lcd_pkg::INIT_STEPS - 1));

    // Commands in send order, each followed by its arguments
    // The two gamma commands span two lines each
    initial begin
        mem = '{
            8'h01,
            8'h28,
            8'hCB, 8'h39, 8'h2C, 8'h00, 8'h34, 8'h02,
            8'hCF, 8'h00, 8'hC1, 8'h30,
            8'hE8, 8'h85, 8'h00, 8'h78,
            8'hEA, 8'h00, 8'h00,
            8'hED, 8'h64, 8'h03, 8'h12, 8'h81,
            8'hF7, 8'h20,
            8'hC0, 8'h23,
            8'hC1, 8'h10,
            8'hC5, 8'h3E, 8'h28,
            8'hC7, 8'h86,
            8'h36, 8'h48,
            8'h3A, 8'h55,
            8'hB1, 8'h00, 8'h18,
            8'hB6, 8'h08, 8'h82, 8'h27,
            8'hF2, 8'h00,
            8'h26, 8'h01,
            8'hE0, 8'h0F, 8'h31, 8'h2B, 8'h0C, 8'h0E, 8'h08, 8'h4E,
            8'hF1, 8'h37, 8'h07, 8'h10, 8'h03, 8'h0E, 8'h09, 8'h00,
            8'hE1, 8'h00, 8'h0E, 8'h14, 8'h03, 8'h11, 8'h07, 8'h31,
            8'hC1, 8'h48, 8'h08, 8'h0F, 8'h0C, 8'h31, 8'h36, 8'h0F,
            8'h11,
            8'h29
        };
    end

    assign data = mem[addr];

endmodule

//--- hw/spi_byte_tx.sv
// SPI mode 0 byte transmitter
`timescale 1ns/10ps
module spi_byte_tx (
    input  logic   CLK_100MHz,
    input  logic   reset,
    spi_byte_if.tx link,
    output logic   tft_cs,
    output logic   tft_sck,
    output logic   tft_sdi,
    output logic   tft_dc
);

    lcd_pkg::tx_state_t state;
    logic [$clog2(lcd_pkg::SCK_HALF)-1:0] half_cnt;
    logic [2:0] bit_cnt;
    lcd_pkg::lcd_byte_t shreg;
    logic half_done;
    logic sck_fall;

    assign half_done = (int'(half_cnt) == lcd_pkg::SCK_HALF - 1);

    // SDI moves on the falling SCK edge
    assign sck_fall = (state == lcd_pkg::shift) && half_done && tft_sck;

    always_ff @(posedge CLK_100MHz) begin
        if (reset) begin
            state <= lcd_pkg::idle;
            tft_cs <= 1'b1;
            tft_sck <= 1'b0;
            link.busy <= 1'b0;
            half_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                lcd_pkg::idle: begin
                    if (link.start) begin
                        tft_cs <= 1'b0;
                        link.busy <= 1'b1;
                        half_cnt <= '0;
                        bit_cnt <= '0;
                        state <= lcd_pkg::shift;
                    end
                end
                lcd_pkg::shift: begin
                    if (half_done) begin
                        half_cnt <= '0;
                        tft_sck <= !tft_sck;
                        if (tft_sck) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            // Eighth falling edge ends the byte
                            if (bit_cnt == 3'd7) begin
                                state <= lcd_pkg::finish;
                            end
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                lcd_pkg::finish: begin
                    tft_cs <= 1'b1;
                    link.busy <= 1'b0;
                    state <= lcd_pkg::idle;
                end
                default: state <= lcd_pkg::idle;
            endcase
        end
    end

    // MSB goes out with chip select, dc holds for the whole frame
    always_ff @(posedge CLK_100MHz) begin
        if (state == lcd_pkg::idle && link.start) begin
            shreg <= link.data;
            tft_sdi <= link.data[7];
            tft_dc <= link.dc;
        end else if (sck_fall) begin
            tft_sdi <= shreg[6];
            shreg <= {shreg[6:0], 1'b0};
        end
    end

endmodule

//--- hw/spi_byte_if.sv
// SPI byte request link
`timescale 1ns/10ps
interface spi_byte_if;

    // One-cycle request strobe, byte and data/command level
    logic start;
    lcd_pkg::lcd_byte_t data;
    logic dc;

    // High from the cycle after start until chip select is back high
    logic busy;

    modport ctrl (
        output start,
        output data,
        output dc,
        input  busy
    );

    modport tx (
        input  start,
        input  data,
        input  dc,
        output busy
    );

endinterface

//--- hw/lcd_pkg.sv
// LCD controller shared definitions
package lcd_pkg;

    // Byte sent to the panel over SPI
    typedef logic [7:0] lcd_byte_t;

    // Init table indexing
    typedef logic [4:0] step_idx_t;
    typedef logic [6:0] rom_addr_t;

    // Wait length in wait ticks
    typedef logic [8:0] wait_t;

    // Reset-pin steps come first, then the command steps
    localparam int PIN_STEPS = 3;
    localparam int INIT_STEPS = 22;

    // Every init byte, commands and arguments
    localparam int ROM_BYTES = 84;

    // System clocks per SCK half period, 12.5 MHz SCK
    localparam int SCK_HALF = 4;

    // Init sequencer and host byte FSM
    typedef enum logic [2:0] {
        reset_wait,
        send_step,
        step_wait,
        ready_idle,
        host_send
    } ctrl_state_t;

    // SPI byte serializer FSM
    typedef enum logic [1:0] {
        idle,
        shift,
        finish
    } tx_state_t;

endpackage
